//--- src/armPkg.sv
// ARM subset core shared definitions
// Widths, instruction field positions and control encodings
package armPkg;

   // Datapath and register index widths
   localparam int wordWidth   = 32;
   localparam int regIdxWidth = 4;

   typedef logic [wordWidth-1:0]   wordT;
   typedef logic [regIdxWidth-1:0] regIdxT;

   // This index reads as PC+8 and is never written
   localparam regIdxT pcIndex = 4'd15;

   // Instruction field positions
   localparam int condMsb = 31;
   localparam int condLsb = 28;
   localparam int opMsb   = 27;
   localparam int opLsb   = 26;
   localparam int immBit  = 25;
   localparam int cmdMsb  = 24;
   localparam int cmdLsb  = 21;
   localparam int sBit    = 20;
   localparam int loadBit = 20;
   localparam int rnMsb   = 19;
   localparam int rnLsb   = 16;
   localparam int rdMsb   = 15;
   localparam int rdLsb   = 12;
   localparam int rmMsb   = 3;
   localparam int rmLsb   = 0;

   // Data processing cmd field codes
   localparam logic [3:0] cmdAnd = 4'b0000;
   localparam logic [3:0] cmdSub = 4'b0010;
   localparam logic [3:0] cmdAdd = 4'b0100;
   localparam logic [3:0] cmdOrr = 4'b1100;

   // Instruction class, bits 27:26
   typedef enum logic [1:0] {
      opDataProc = 2'b00,
      opMemory   = 2'b01,
      opBranch   = 2'b10
   } opT;

   // ALU operation select
   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluOrr = 2'b11
   } aluCtrlT;

   // Immediate extension kinds
   typedef enum logic [1:0] {
      immByte   = 2'b00,
      immOffset = 2'b01,
      immBranch = 2'b10
   } immSelT;

   // Condition field, 1111 left out and handled as never
   typedef enum logic [3:0] {
      condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
      condHi, condLs, condGe, condLt, condGt, condLe, condAl
   } condT;

   // Status flags in CPSR order
   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flagsT;

endpackage

//--- src/aluUnit.sv
// 32-bit ALU for add, sub, and, orr
// Produces NZCV, with C and V cleared on logic ops
`timescale 1ns/1ps

module aluUnit (
   input  armPkg::wordT    a,
   input  armPkg::wordT    b,
   input  armPkg::aluCtrlT aluCtrl,
   output armPkg::wordT    result,
   output armPkg::flagsT   flags
);

   logic                          isSub;
   logic                          isArith;
   armPkg::wordT                  bMod;
   logic [armPkg::wordWidth:0]    sum;

   // Subtract as a + ~b + 1
   assign isSub   = (aluCtrl == armPkg::aluSub);
   assign isArith = (aluCtrl == armPkg::aluAdd) || isSub;
   assign bMod    = isSub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bMod} + {{armPkg::wordWidth{1'b0}}, isSub};

   always_comb
   begin
      case (aluCtrl)
         armPkg::aluAnd: result = a & b;
         armPkg::aluOrr: result = a | b;
         default:        result = sum[armPkg::wordWidth-1:0];
      endcase
   end

   assign flags.neg   = result[armPkg::wordWidth-1];
   assign flags.zero  = (result == '0);
   // Carry out means no borrow on subtract
   assign flags.carry = isArith & sum[armPkg::wordWidth];
   // Operand signs agree and result sign differs
   assign flags.overflow = isArith
                         & ~(a[armPkg::wordWidth-1] ^ b[armPkg::wordWidth-1] ^ isSub)
                         & (a[armPkg::wordWidth-1] ^ sum[armPkg::wordWidth-1]);

endmodule

//--- src/regFile.sv
// Register file, R0 to R14 with two reads and one write
// R15 reads as PC+8
`timescale 1ns/1ps

module regFile (
   input  logic           clk,
   input  logic           reset,
   input  logic           writeEn,
   input  armPkg::regIdxT readAddr1,
   input  armPkg::regIdxT readAddr2,
   input  armPkg::regIdxT writeAddr,
   input  armPkg::wordT   writeData,
   input  armPkg::wordT   pcPlus8,
   output armPkg::wordT   readData1,
   output armPkg::wordT   readData2
);

   // Fifteen general registers
   armPkg::wordT regs [0:armPkg::pcIndex-1];

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < armPkg::pcIndex; i++)
            regs[i] <= '0;
      end
      else if (writeEn && (writeAddr != armPkg::pcIndex))
      begin
         regs[writeAddr] <= writeData;
      end
   end

   // Combinational reads
   assign readData1 = (readAddr1 == armPkg::pcIndex) ? pcPlus8 : regs[readAddr1];
   assign readData2 = (readAddr2 == armPkg::pcIndex) ? pcPlus8 : regs[readAddr2];

endmodule

//--- src/instrDecoder.sv
// Main and ALU decoder
// Turns op and funct fields into datapath and write request controls
`timescale 1ns/1ps

module instrDecoder (
   input  armPkg::wordT    instr,
   output logic [1:0]      flagWrite,
   output logic            pcSel,
   output logic            regWriteReq,
   output logic            memWriteReq,
   output logic            memToReg,
   output logic            aluSrcImm,
   output armPkg::immSelT  immSel,
   output logic [1:0]      regSrc,
   output armPkg::aluCtrlT aluCtrl,
   output logic            dataStrobe
);

   logic cmdValid;
   logic cmdArith;

   always_comb
   begin
      // Default is a no-op with nothing written
      flagWrite   = 2'b00;
      pcSel       = 1'b0;
      regWriteReq = 1'b0;
      memWriteReq = 1'b0;
      memToReg    = 1'b0;
      aluSrcImm   = 1'b0;
      immSel      = armPkg::immByte;
      regSrc      = 2'b00;
      aluCtrl     = armPkg::aluAdd;
      dataStrobe  = 1'b0;
      cmdValid    = 1'b0;
      cmdArith    = 1'b0;

      case (armPkg::opT'(instr[armPkg::opMsb:armPkg::opLsb]))
         armPkg::opDataProc:
         begin
            aluSrcImm = instr[armPkg::immBit];
            // ALU decoder, four supported cmds
            case (instr[armPkg::cmdMsb:armPkg::cmdLsb])
               armPkg::cmdAdd:
               begin
                  aluCtrl  = armPkg::aluAdd;
                  cmdValid = 1'b1;
                  cmdArith = 1'b1;
               end
               armPkg::cmdSub:
               begin
                  aluCtrl  = armPkg::aluSub;
                  cmdValid = 1'b1;
                  cmdArith = 1'b1;
               end
               armPkg::cmdAnd:
               begin
                  aluCtrl  = armPkg::aluAnd;
                  cmdValid = 1'b1;
               end
               armPkg::cmdOrr:
               begin
                  aluCtrl  = armPkg::aluOrr;
                  cmdValid = 1'b1;
               end
               default:
               begin
                  cmdValid = 1'b0;
               end
            endcase
            regWriteReq = cmdValid;
            // N/Z on any valid op, C/V on add and sub only
            flagWrite[1] = instr[armPkg::sBit] & cmdValid;
            flagWrite[0] = instr[armPkg::sBit] & cmdArith;
         end
         armPkg::opMemory:
         begin
            // Address is rn plus zero-extended offset
            aluSrcImm  = 1'b1;
            immSel     = armPkg::immOffset;
            dataStrobe = 1'b1;
            if (instr[armPkg::loadBit])
            begin
               regWriteReq = 1'b1;
               memToReg    = 1'b1;
            end
            else
            begin
               // Store data comes from rd on port 2
               memWriteReq = 1'b1;
               regSrc[1]   = 1'b1;
            end
         end
         armPkg::opBranch:
         begin
            // Target is R15 plus shifted offset
            aluSrcImm = 1'b1;
            immSel    = armPkg::immBranch;
            regSrc[0] = 1'b1;
            pcSel     = 1'b1;
         end
         default:
         begin
            pcSel = 1'b0;
         end
      endcase
   end

endmodule

//--- src/condUnit.sv
// Condition unit
// Holds the NZCV flags and gates all write enables by condition and stall
`timescale 1ns/1ps

module condUnit (
   input  logic          clk,
   input  logic          reset,
   input  armPkg::condT  cond,
   input  armPkg::flagsT aluFlags,
   input  logic [1:0]    flagWrite,
   input  logic          pcSel,
   input  logic          regWriteReq,
   input  logic          memWriteReq,
   input  logic          pcReady,
   output logic          pcBranch,
   output logic          regWrite,
   output logic          memWrite
);

   armPkg::flagsT flags;
   logic          condEx;
   logic          commit;
   logic [1:0]    flagEn;
   logic          ge;

   // Signed compare helper
   assign ge = (flags.neg == flags.overflow);

   always_comb
   begin
      case (cond)
         armPkg::condEq: condEx = flags.zero;
         armPkg::condNe: condEx = ~flags.zero;
         armPkg::condCs: condEx = flags.carry;
         armPkg::condCc: condEx = ~flags.carry;
         armPkg::condMi: condEx = flags.neg;
         armPkg::condPl: condEx = ~flags.neg;
         armPkg::condVs: condEx = flags.overflow;
         armPkg::condVc: condEx = ~flags.overflow;
         armPkg::condHi: condEx = flags.carry & ~flags.zero;
         armPkg::condLs: condEx = ~flags.carry | flags.zero;
         armPkg::condGe: condEx = ge;
         armPkg::condLt: condEx = ~ge;
         armPkg::condGt: condEx = ~flags.zero & ge;
         armPkg::condLe: condEx = flags.zero | ~ge;
         armPkg::condAl: condEx = 1'b1;
         // 1111 never executes
         default:        condEx = 1'b0;
      endcase
   end

   // Nothing commits while stalled
   assign commit = condEx & pcReady;

   assign flagEn   = flagWrite & {2{commit}};
   assign regWrite = regWriteReq & commit;
   // No store reaches memory while in reset
   assign memWrite = memWriteReq & commit & ~reset;
   assign pcBranch = pcSel & commit;

   // N/Z and C/V pairs load separately
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         flags <= '0;
      end
      else
      begin
         if (flagEn[1])
         begin
            flags.neg  <= aluFlags.neg;
            flags.zero <= aluFlags.zero;
         end
         if (flagEn[0])
         begin
            flags.carry    <= aluFlags.carry;
            flags.overflow <= aluFlags.overflow;
         end
      end
   end

endmodule

//--- src/datapath.sv
// Core datapath
// PC, register addressing, immediate extension, ALU and result select
`timescale 1ns/1ps

module datapath (
   input  logic            clk,
   input  logic            reset,
   input  armPkg::wordT    instr,
   input  armPkg::wordT    readData,
   input  logic            regWrite,
   input  logic            pcBranch,
   input  logic            pcReady,
   input  armPkg::aluCtrlT aluCtrl,
   input  armPkg::immSelT  immSel,
   input  logic            aluSrcImm,
   input  logic            memToReg,
   input  logic [1:0]      regSrc,
   output armPkg::wordT    pc,
   output armPkg::wordT    dataAddr,
   output armPkg::wordT    writeData,
   output armPkg::flagsT   aluFlags
);

   armPkg::wordT   pcNext;
   armPkg::wordT   pcPlus4;
   armPkg::wordT   pcPlus8;
   armPkg::wordT   extImm;
   armPkg::wordT   srcA;
   armPkg::wordT   srcB;
   armPkg::wordT   aluResult;
   armPkg::wordT   result;
   armPkg::regIdxT readAddr1;
   armPkg::regIdxT readAddr2;

   // Next PC, branch target comes straight from the ALU
   assign pcPlus4 = pc + 32'd4;
   assign pcPlus8 = pc + 32'd8;
   assign pcNext  = pcBranch ? aluResult : pcPlus4;

   // PC holds while stalled
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (pcReady)
         pc <= pcNext;
   end

   // Branches read R15 on port 1, stores read rd on port 2
   assign readAddr1 = regSrc[0] ? armPkg::pcIndex : instr[armPkg::rnMsb:armPkg::rnLsb];
   assign readAddr2 = regSrc[1] ? instr[armPkg::rdMsb:armPkg::rdLsb]
                                : instr[armPkg::rmMsb:armPkg::rmLsb];

   regFile i_regFile (
      .clk       (clk),
      .reset     (reset),
      .writeEn   (regWrite),
      .readAddr1 (readAddr1),
      .readAddr2 (readAddr2),
      .writeAddr (instr[armPkg::rdMsb:armPkg::rdLsb]),
      .writeData (result),
      .pcPlus8   (pcPlus8),
      .readData1 (srcA),
      .readData2 (writeData)
   );

   // Immediate extension
   always_comb
   begin
      case (immSel)
         armPkg::immByte:   extImm = {24'b0, instr[7:0]};
         armPkg::immOffset: extImm = {20'b0, instr[11:0]};
         // Signed word offset
         armPkg::immBranch: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};
         default:           extImm = '0;
      endcase
   end

   assign srcB = aluSrcImm ? extImm : writeData;

   aluUnit i_aluUnit (
      .a       (srcA),
      .b       (srcB),
      .aluCtrl (aluCtrl),
      .result  (aluResult),
      .flags   (aluFlags)
   );

   // Loads write back memory data
   assign result   = memToReg ? readData : aluResult;
   assign dataAddr = aluResult;

endmodule

//--- src/armCore.sv
// ARM subset single-cycle core top
// Joins the decoder, the condition unit and the datapath
`timescale 1ns/1ps

module armCore (
   input  logic        clk,
   input  logic        reset,
   input  armPkg::wordT instr,
   input  armPkg::wordT readData,
   input  logic        pcReady,
   output armPkg::wordT pc,
   output armPkg::wordT dataAddr,
   output armPkg::wordT writeData,
   output logic        memWrite,
   output logic        dataStrobe
);

   // Decoder requests, before condition gating
   logic [1:0] flagWrite;
   logic       pcSel;
   logic       regWriteReq;
   logic       memWriteReq;

   // Datapath controls
   logic                  memToReg;
   logic                  aluSrcImm;
   logic [1:0]            regSrc;
   armPkg::immSelT        immSel;
   armPkg::aluCtrlT       aluCtrl;

   // Gated enables and ALU flags
   logic          pcBranch;
   logic          regWrite;
   armPkg::flagsT aluFlags;

   instrDecoder i_instrDecoder (
      .instr       (instr),
      .flagWrite   (flagWrite),
      .pcSel       (pcSel),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .memToReg    (memToReg),
      .aluSrcImm   (aluSrcImm),
      .immSel      (immSel),
      .regSrc      (regSrc),
      .aluCtrl     (aluCtrl),
      .dataStrobe  (dataStrobe)
   );

   condUnit i_condUnit (
      .clk         (clk),
      .reset       (reset),
      .cond        (armPkg::condT'(instr[armPkg::condMsb:armPkg::condLsb])),
      .aluFlags    (aluFlags),
      .flagWrite   (flagWrite),
      .pcSel       (pcSel),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .pcReady     (pcReady),
      .pcBranch    (pcBranch),
      .regWrite    (regWrite),
      .memWrite    (memWrite)
   );

   datapath i_datapath (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .readData  (readData),
      .regWrite  (regWrite),
      .pcBranch  (pcBranch),
      .pcReady   (pcReady),
      .aluCtrl   (aluCtrl),
      .immSel    (immSel),
      .aluSrcImm (aluSrcImm),
      .memToReg  (memToReg),
      .regSrc    (regSrc),
      .pc        (pc),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .aluFlags  (aluFlags)
   );

endmodule

//--- dv/armCoreAssertions.sv
// Bound checks on the ARM core outputs
// Store strobe, stall hold of the PC and quiet memWrite in reset
`timescale 1ns/1ps

module armCoreAssertions (
   input logic         clk,
   input logic         reset,
   input logic         pcReady,
   input logic         memWrite,
   input logic         dataStrobe,
   input armPkg::wordT pc
);

   // Read by the testbench at the end of the run
   int failCount = 0;

   // A store is always a data access
   storeHasStrobe: assert property (@(posedge clk) disable iff (reset) memWrite |-> dataStrobe)
      else
      begin
         $error("memWrite high without dataStrobe");
         failCount++;
      end

   // Stalled edge leaves the PC alone
   stallHoldsPc: assert property (@(posedge clk) disable iff (reset) !pcReady |=> $stable(pc))
      else
      begin
         $error("pc changed across a stalled edge");
         failCount++;
      end

   resetNoWrite: assert property (@(posedge clk) reset |-> !memWrite)
      else
      begin
         $error("memWrite high during reset");
         failCount++;
      end

endmodule

bind armCore armCoreAssertions i_armCoreAssertions (
   .clk        (clk),
   .reset      (reset),
   .pcReady    (pcReady),
   .memWrite   (memWrite),
   .dataStrobe (dataStrobe),
   .pc         (pc)
);

//--- dv/armCoreStim.svh
// Stimulus and reference model for the ARM core testbench
// LFSR, random program builder, ISA model and the value check
`ifndef ARMCORESTIM_SVH
`define ARMCORESTIM_SVH

// Architectural state of the reference model
logic [15:0]   lfsrState = 16'd15;
armPkg::wordT  modelRegs [0:14];
armPkg::wordT  modelMem [0:63];
armPkg::wordT  modelPc;
armPkg::flagsT modelFlags;

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic lfsrStep();
   logic fb;
   fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
   lfsrState = {lfsrState[14:0], fb};
   return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] randBits(input int n);
   logic [31:0] v;
   v = '0;
   for (int k = 0; k < n; k++)
      v = {v[30:0], lfsrStep()};
   return v;
endfunction

// Random data processing, LDR/STR or short forward branch
function automatic armPkg::wordT genInstr();
   logic [31:0]  rnd;
   armPkg::wordT ins;
   ins = '0;
   rnd = randBits(4);
   ins[armPkg::condMsb:armPkg::condLsb] = rnd[3:0];
   rnd = randBits(4);
   ins[armPkg::rnMsb:armPkg::rnLsb] = rnd[3:0];
   // rd stays below 15
   rnd = randBits(4) % 32'd15;
   ins[armPkg::rdMsb:armPkg::rdLsb] = rnd[3:0];
   rnd = randBits(2);
   if (rnd[1] == 1'b0)
   begin
      rnd = randBits(2);
      case (rnd[1:0])
         2'd0:    ins[armPkg::cmdMsb:armPkg::cmdLsb] = armPkg::cmdAdd;
         2'd1:    ins[armPkg::cmdMsb:armPkg::cmdLsb] = armPkg::cmdSub;
         2'd2:    ins[armPkg::cmdMsb:armPkg::cmdLsb] = armPkg::cmdAnd;
         default: ins[armPkg::cmdMsb:armPkg::cmdLsb] = armPkg::cmdOrr;
      endcase
      rnd = randBits(2);
      ins[armPkg::immBit] = rnd[0];
      ins[armPkg::sBit]   = rnd[1];
      rnd = randBits(8);
      if (ins[armPkg::immBit])
         ins[7:0] = rnd[7:0];
      else
         ins[3:0] = rnd[3:0];
   end
   else if (rnd[0] == 1'b0)
   begin
      // P=1 U=1, offset below 64
      ins[27:26] = 2'b01;
      ins[24:23] = 2'b11;
      rnd = randBits(1);
      ins[armPkg::loadBit] = rnd[0];
      rnd = randBits(6);
      ins[11:0] = {6'b0, rnd[5:0]};
   end
   else
   begin
      // 0 to 3 words forward
      ins[27:25] = 3'b101;
      rnd = randBits(2);
      ins[23:0] = {22'b0, rnd[1:0]};
   end
   return ins;
endfunction

// ISA condition table
function automatic logic condPass(input logic [3:0] c, input armPkg::flagsT f);
   case (c)
      4'h0:    return f.zero;
      4'h1:    return !f.zero;
      4'h2:    return f.carry;
      4'h3:    return !f.carry;
      4'h4:    return f.neg;
      4'h5:    return !f.neg;
      4'h6:    return f.overflow;
      4'h7:    return !f.overflow;
      4'h8:    return f.carry && !f.zero;
      4'h9:    return !f.carry || f.zero;
      4'hA:    return f.neg == f.overflow;
      4'hB:    return f.neg != f.overflow;
      4'hC:    return !f.zero && (f.neg == f.overflow);
      4'hD:    return f.zero || (f.neg != f.overflow);
      4'hE:    return 1'b1;
      default: return 1'b0;
   endcase
endfunction

// R15 reads as PC+8
function automatic armPkg::wordT readReg(input logic [3:0] idx);
   return (idx == 4'd15) ? modelPc + 32'd8 : modelRegs[idx];
endfunction

// Executes one instruction, returns the expected store
task automatic modelStep(input armPkg::wordT ins, output logic storeEn,
                         output armPkg::wordT addr, output armPkg::wordT data);
   logic         pass;
   logic [32:0]  wide;
   logic [3:0]   cmd;
   logic [3:0]   rd;
   armPkg::wordT a;
   armPkg::wordT b;
   armPkg::wordT res;
   armPkg::wordT nextPc;
   pass    = condPass(ins[31:28], modelFlags);
   cmd     = ins[24:21];
   rd      = ins[15:12];
   a       = readReg(ins[19:16]);
   nextPc  = modelPc + 32'd4;
   storeEn = 1'b0;
   addr    = '0;
   data    = '0;
   case (ins[27:26])
      2'b00:
      begin
         b = ins[25] ? {24'b0, ins[7:0]} : readReg(ins[3:0]);
         case (cmd)
            armPkg::cmdAdd: wide = {1'b0, a} + {1'b0, b};
            armPkg::cmdSub: wide = {1'b0, a} - {1'b0, b};
            armPkg::cmdAnd: wide = {1'b0, a & b};
            default:        wide = {1'b0, a | b};
         endcase
         res = wide[31:0];
         if (pass)
         begin
            modelRegs[rd] = res;
            if (ins[20])
            begin
               modelFlags.neg  = res[31];
               modelFlags.zero = (res == 32'd0);
               // C is carry out on add, no borrow on sub
               if (cmd == armPkg::cmdAdd)
               begin
                  modelFlags.carry    = wide[32];
                  modelFlags.overflow = (a[31] == b[31]) && (res[31] != a[31]);
               end
               else if (cmd == armPkg::cmdSub)
               begin
                  modelFlags.carry    = (a >= b);
                  modelFlags.overflow = (a[31] != b[31]) && (res[31] != a[31]);
               end
            end
         end
      end
      2'b01:
      begin
         addr = a + {20'b0, ins[11:0]};
         if (pass && ins[20])
            modelRegs[rd] = modelMem[addr[7:2]];
         else if (pass)
         begin
            storeEn = 1'b1;
            data    = readReg(rd);
            modelMem[addr[7:2]] = data;
         end
      end
      2'b10:
      begin
         if (pass)
            nextPc = modelPc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
      end
      default:
      begin
         nextPc = modelPc + 32'd4;
      end
   endcase
   modelPc = nextPc;
endtask

// Compare one DUT output with its expected value
task automatic checkValue(input string name, input armPkg::wordT actual,
                          input armPkg::wordT expected);
   if (actual !== expected)
   begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      failRun("value mismatch");
   end
endtask

`endif

//--- dv/armCoreTb.sv
// ARM core testbench
// Random program, lockstep ISA model, stalls and a watchdog
`timescale 1ns/1ps

module armCoreTb;

   localparam int clkPeriod   = 40;
   localparam int resetCycles = 16;
   localparam int progLen     = 64;
   localparam int tailLen     = 15;
   localparam int tailEnd     = 4 * (progLen + tailLen);
   // R15 based offset, tail stores land at 0x400 + 4*n
   localparam logic [11:0] tailOffset = 12'h2F8;

   logic         clk;
   logic         reset;
   logic         pcReady;
   armPkg::wordT instr;
   armPkg::wordT readData;
   armPkg::wordT pc;
   armPkg::wordT dataAddr;
   armPkg::wordT writeData;
   logic         memWrite;
   logic         dataStrobe;

   // Instruction and data memories
   armPkg::wordT instrMem [0:127];
   armPkg::wordT dataMem [0:63];

   logic         expStore;
   logic         expStrobe;
   armPkg::wordT expAddr;
   armPkg::wordT expData;

   armCore i_armCore (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .readData   (readData),
      .pcReady    (pcReady),
      .pc         (pc),
      .dataAddr   (dataAddr),
      .writeData  (writeData),
      .memWrite   (memWrite),
      .dataStrobe (dataStrobe)
   );

   // Combinational fetch and load data
   assign instr    = instrMem[pc[8:2]];
   assign readData = dataMem[dataAddr[7:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         dataMem[dataAddr[7:2]] <= writeData;
   end

   task automatic failRun(input string why);
      $display("Simulation finished: FAIL");
      $fatal(1, "%s", why);
   endtask

   `include "armCoreStim.svh"

   // Initial data memory contents, every address distinct
   function automatic armPkg::wordT fillWord(input int idx);
      return (32'h9E37_79B9 * (idx + 1)) ^ {idx[7:0], 24'h0};
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Reset time plus four cycles per instruction
   initial
   begin
      #(clkPeriod * (resetCycles + 4 * (progLen + tailLen)));
      $display("Timeout: pc did not pass the end of the program in time");
      failRun("watchdog expired");
   end

   initial
   begin
      reset   = 1'b1;
      // Not stalled during reset, so a store at pc 0 must still stay quiet
      pcReady = 1'b1;
      for (int i = 0; i < 128; i++)
         instrMem[i] = 32'hF000_0000;
      for (int i = 0; i < 64; i++)
      begin
         dataMem[i]  = fillWord(i);
         modelMem[i] = fillWord(i);
      end
      for (int i = 0; i < 15; i++)
         modelRegs[i] = '0;
      modelFlags = '0;
      modelPc    = '0;
      for (int i = 0; i < progLen; i++)
         instrMem[i] = genInstr();
      // STR AL rN, [r15, #tailOffset]
      for (int i = 0; i < tailLen; i++)
         instrMem[progLen + i] = {4'hE, 8'b0101_1000, 4'hF, i[3:0], tailOffset};

      repeat (resetCycles) @(negedge clk);
      checkValue("pc", pc, 32'd0);
      checkValue("memWrite", memWrite, 32'd0);
      reset = 1'b0;

      // Drive on the falling edge, check a quarter period later
      while (modelPc < tailEnd)
      begin
         pcReady = (randBits(2) != 32'd0);
         #(clkPeriod / 4);
         checkValue("pc", pc, modelPc);
         // Any LDR or STR is a data access, whatever its condition
         expStrobe = (instrMem[modelPc[8:2]][27:26] == 2'b01);
         checkValue("dataStrobe", dataStrobe, expStrobe);
         if (pcReady)
         begin
            modelStep(instrMem[modelPc[8:2]], expStore, expAddr, expData);
            checkValue("memWrite", memWrite, expStore);
            if (expStrobe)
               checkValue("dataAddr", dataAddr, expAddr);
            if (expStore)
               checkValue("writeData", writeData, expData);
         end
         else
            checkValue("memWrite", memWrite, 32'd0);
         @(negedge clk);
      end
      checkValue("pc", pc, modelPc);

      if (i_armCore.i_armCoreAssertions.failCount == 0)
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
      else
         failRun("bound assertions reported failures");
   end

endmodule

//--- vlog.f
+incdir+dv
src/armPkg.sv
src/aluUnit.sv
src/regFile.sv
src/instrDecoder.sv
src/condUnit.sv
src/datapath.sv
src/armCore.sv
dv/armCoreAssertions.sv
dv/armCoreTb.sv
